// ==== hdc_macros.svh ====
`ifndef HDC_MACROS_SVH
`define HDC_MACROS_SVH

// hypervector width in bits
`define HDC_DIM 64

// item memory depth, one hypervector per symbol
`define HDC_ITEMS 16

// symbol address width
// must cover HDC_ITEMS
`define HDC_SYM_W 4

// number of parallel encoder lanes
`define HDC_LANES 4

// lane index width
`define HDC_LANE_W 2

// rotation position width
// covers positions 0 to HDC_DIM-1
`define HDC_POS_W 6

`endif

// ==== hdc_pkg.sv ====
`default_nettype none
`include "hdc_macros.svh"

package hdc_pkg;

    // one hypervector
    typedef logic [`HDC_DIM-1:0] hv_t;

    // item memory address
    typedef logic [`HDC_SYM_W-1:0] sym_t;

    // lane index
    typedef logic [`HDC_LANE_W-1:0] lane_t;

    // rotation amount / position inside the n-gram window
    typedef logic [`HDC_POS_W-1:0] pos_t;

    // host command opcodes
    typedef enum logic [2:0] {
        OP_CONFIG    = 3'd0,
        OP_LOAD_ITEM = 3'd1,
        OP_START     = 3'd2,
        OP_ACCUM     = 3'd3,
        OP_READ      = 3'd4
    } hdc_op_e;

    // command receiver FSM
    typedef enum logic [1:0] {
        DS_IDLE,
        DS_ISSUE,
        DS_WAIT_DROP
    } disp_state_e;

    // result drain FSM
    typedef enum logic [1:0] {
        CS_SCAN,
        CS_REQ,
        CS_WAIT_DROP
    } coll_state_e;

endpackage

`default_nettype wire

// ==== hdc_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "hdc_macros.svh"

module hdc_dispatch (
    input  wire                      clk,
    input  wire                      rst_n,
    // host command port, four-phase
    input  wire                      cmd_req,
    input  wire hdc_pkg::hdc_op_e    cmd_op,
    input  wire hdc_pkg::lane_t      cmd_lane,
    input  wire hdc_pkg::sym_t       cmd_sym,
    input  wire hdc_pkg::hv_t        cmd_hv,
    output logic                     cmd_ack,
    // lane side
    input  wire [`HDC_LANES-1:0]     res_busy,
    output logic                     wr_en,
    output hdc_pkg::sym_t            wr_addr,
    output hdc_pkg::hv_t             wr_data,
    output logic [`HDC_LANES-1:0]    op_start,
    output logic [`HDC_LANES-1:0]    op_accum,
    output logic [`HDC_LANES-1:0]    op_read,
    output hdc_pkg::sym_t            op_sym,
    output hdc_pkg::pos_t            ngram_len
);

    hdc_pkg::disp_state_e state_q;

    // captured command, stable until the next DS_IDLE capture
    hdc_pkg::hdc_op_e     op_q;
    hdc_pkg::lane_t       lane_q;
    hdc_pkg::sym_t        sym_q;
    hdc_pkg::hv_t         hv_q;

    // read must wait while the target lane still holds a result
    logic                 read_blocked;

    assign read_blocked = (op_q == hdc_pkg::OP_READ) && res_busy[lane_q];

    // write port and symbol come straight from the captured command
    assign wr_addr = sym_q;
    assign wr_data = hv_q;
    assign op_sym  = sym_q;

    // command capture, payload only
    always_ff @(posedge clk) begin
        if (state_q == hdc_pkg::DS_IDLE && cmd_req) begin
            op_q   <= cmd_op;
            lane_q <= cmd_lane;
            sym_q  <= cmd_sym;
            hv_q   <= cmd_hv;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= hdc_pkg::DS_IDLE;
            cmd_ack   <= 1'b0;
            wr_en     <= 1'b0;
            op_start  <= '0;
            op_accum  <= '0;
            op_read   <= '0;
            // HDC_DIM truncates to 0 in pos_t, i.e. the full window
            ngram_len <= hdc_pkg::pos_t'(`HDC_DIM);
        end else begin
            // strobes last one cycle
            wr_en    <= 1'b0;
            op_start <= '0;
            op_accum <= '0;
            op_read  <= '0;
            case (state_q)
                hdc_pkg::DS_IDLE: begin
                    if (cmd_req) begin
                        state_q <= hdc_pkg::DS_ISSUE;
                    end
                end
                hdc_pkg::DS_ISSUE: begin
                    // back-pressure: hold here, no pulse and no ack
                    if (!read_blocked) begin
                        case (op_q)
                            hdc_pkg::OP_CONFIG:    ngram_len <= hv_q[`HDC_POS_W-1:0];
                            hdc_pkg::OP_LOAD_ITEM: wr_en <= 1'b1;
                            hdc_pkg::OP_START:     op_start[lane_q] <= 1'b1;
                            hdc_pkg::OP_ACCUM:     op_accum[lane_q] <= 1'b1;
                            hdc_pkg::OP_READ:      op_read[lane_q] <= 1'b1;
                            // unknown opcode just gets acked
                            default: ;
                        endcase
                        cmd_ack <= 1'b1;
                        state_q <= hdc_pkg::DS_WAIT_DROP;
                    end
                end
                hdc_pkg::DS_WAIT_DROP: begin
                    // ack falls once req is seen low
                    if (!cmd_req) begin
                        cmd_ack <= 1'b0;
                        state_q <= hdc_pkg::DS_IDLE;
                    end
                end
                default: begin
                    state_q <= hdc_pkg::DS_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdc_lane.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "hdc_macros.svh"

module hdc_lane (
    input  wire                   clk,
    input  wire                   rst_n,
    // broadcast item write
    input  wire                   wr_en,
    input  wire hdc_pkg::sym_t    wr_addr,
    input  wire hdc_pkg::hv_t     wr_data,
    // per-lane operation strobes
    input  wire                   op_start,
    input  wire                   op_accum,
    input  wire                   op_read,
    input  wire hdc_pkg::sym_t    op_sym,
    input  wire hdc_pkg::pos_t    ngram_len,
    // result handoff
    input  wire                   res_take,
    output logic                  res_valid,
    output logic                  res_busy,
    output hdc_pkg::hv_t          res_hv
);

    // rotate right by sh, done on a doubled vector
    function automatic hdc_pkg::hv_t rotr(input hdc_pkg::hv_t v, input hdc_pkg::pos_t sh);
        logic [2*`HDC_DIM-1:0] dbl;
        dbl = {v, v} >> sh;
        return dbl[`HDC_DIM-1:0];
    endfunction

    // item vectors, host loaded
    (* ram_style = "block" *)
    hdc_pkg::hv_t item_mem [`HDC_ITEMS];

    // stage 1: registered item read and op flags
    hdc_pkg::hv_t  hv_q;
    logic          s1_start;
    logic          s1_accum;
    logic          s1_read;

    // stage 2 state
    hdc_pkg::hv_t  enc_q;
    hdc_pkg::pos_t pos_q;

    // position update
    hdc_pkg::pos_t pos_last;
    hdc_pkg::pos_t pos_base;
    hdc_pkg::pos_t pos_next;

    // write lands at the next edge
    always_ff @(posedge clk) begin
        if (wr_en) begin
            item_mem[wr_addr] <= wr_data;
        end
    end

    // read is only needed for start and accumulate
    always_ff @(posedge clk) begin
        if (op_start || op_accum) begin
            hv_q <= item_mem[op_sym];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_start <= 1'b0;
            s1_accum <= 1'b0;
            s1_read  <= 1'b0;
        end else begin
            s1_start <= op_start;
            s1_accum <= op_accum;
            s1_read  <= op_read;
        end
    end

    // len 0 stands for the full dimension, last position 63
    assign pos_last = ngram_len - 1'b1;
    // start restarts the window at position 0
    assign pos_base = s1_start ? '0 : pos_q;
    // >= also catches a window shrunk mid-stream
    assign pos_next = (pos_base >= pos_last) ? '0 : pos_base + 1'b1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enc_q <= '0;
            pos_q <= '0;
        end else if (s1_start) begin
            // first symbol, no rotation
            enc_q <= hv_q;
            pos_q <= pos_next;
        end else if (s1_accum) begin
            enc_q <= enc_q ^ rotr(hv_q, pos_q);
            pos_q <= pos_next;
        end
    end

    // result snapshot, held until the collector takes it
    always_ff @(posedge clk) begin
        if (s1_read) begin
            res_hv <= enc_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else if (s1_read) begin
            res_valid <= 1'b1;
        end else if (res_take) begin
            res_valid <= 1'b0;
        end
    end

    // full result register blocks further reads at the dispatcher
    assign res_busy = res_valid;

endmodule

`default_nettype wire

// ==== hdc_collect.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "hdc_macros.svh"

module hdc_collect (
    input  wire                   clk,
    input  wire                   rst_n,
    // lane results
    input  wire [`HDC_LANES-1:0]  res_valid,
    input  wire hdc_pkg::hv_t     res_hv [`HDC_LANES],
    output logic [`HDC_LANES-1:0] res_take,
    // output port, four-phase
    output logic                  out_req,
    output hdc_pkg::lane_t        out_lane,
    output hdc_pkg::hv_t          out_hv,
    input  wire                   out_ack
);

    hdc_pkg::coll_state_e state_q;

    // last lane served, scan starts just after it
    hdc_pkg::lane_t last_q;

    logic           found;
    hdc_pkg::lane_t pick;

    // round-robin pick and take strobe
    always_comb begin
        int idx;
        found    = 1'b0;
        pick     = last_q;
        res_take = '0;
        for (int k = 1; k <= `HDC_LANES; k++) begin
            idx = (int'(last_q) + k) % `HDC_LANES;
            if (!found && res_valid[idx]) begin
                found = 1'b1;
                pick  = hdc_pkg::lane_t'(idx);
            end
        end
        // take only while idle, one lane at a time
        if (state_q == hdc_pkg::CS_SCAN && found) begin
            res_take[pick] = 1'b1;
        end
    end

    // output payload, captured with the take
    always_ff @(posedge clk) begin
        if (state_q == hdc_pkg::CS_SCAN && found) begin
            out_lane <= pick;
            out_hv   <= res_hv[pick];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= hdc_pkg::CS_SCAN;
            out_req <= 1'b0;
            // first scan begins at lane 0
            last_q  <= hdc_pkg::lane_t'(`HDC_LANES - 1);
        end else begin
            case (state_q)
                hdc_pkg::CS_SCAN: begin
                    if (found) begin
                        last_q  <= pick;
                        out_req <= 1'b1;
                        state_q <= hdc_pkg::CS_REQ;
                    end
                end
                hdc_pkg::CS_REQ: begin
                    // slow ack stalls the drain here
                    if (out_ack) begin
                        out_req <= 1'b0;
                        state_q <= hdc_pkg::CS_WAIT_DROP;
                    end
                end
                hdc_pkg::CS_WAIT_DROP: begin
                    if (!out_ack) begin
                        state_q <= hdc_pkg::CS_SCAN;
                    end
                end
                default: begin
                    state_q <= hdc_pkg::CS_SCAN;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdc_ngram_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "hdc_macros.svh"

module hdc_ngram_top (
    input  wire                   clk,
    input  wire                   rst_n,
    // host command port
    input  wire                   cmd_req,
    input  wire hdc_pkg::hdc_op_e cmd_op,
    input  wire hdc_pkg::lane_t   cmd_lane,
    input  wire hdc_pkg::sym_t    cmd_sym,
    input  wire hdc_pkg::hv_t     cmd_hv,
    output logic                  cmd_ack,
    // result port
    output logic                  out_req,
    output hdc_pkg::lane_t        out_lane,
    output hdc_pkg::hv_t          out_hv,
    input  wire                   out_ack
);

    // dispatcher to lanes
    logic                  wr_en;
    hdc_pkg::sym_t         wr_addr;
    hdc_pkg::hv_t          wr_data;
    logic [`HDC_LANES-1:0] op_start;
    logic [`HDC_LANES-1:0] op_accum;
    logic [`HDC_LANES-1:0] op_read;
    hdc_pkg::sym_t         op_sym;
    hdc_pkg::pos_t         ngram_len;
    logic [`HDC_LANES-1:0] res_busy;

    // lanes to collector
    logic [`HDC_LANES-1:0] res_valid;
    logic [`HDC_LANES-1:0] res_take;
    hdc_pkg::hv_t          res_hv [`HDC_LANES];

    hdc_dispatch u_hdc_dispatch (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_req   (cmd_req),
        .cmd_op    (cmd_op),
        .cmd_lane  (cmd_lane),
        .cmd_sym   (cmd_sym),
        .cmd_hv    (cmd_hv),
        .cmd_ack   (cmd_ack),
        .res_busy  (res_busy),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .op_start  (op_start),
        .op_accum  (op_accum),
        .op_read   (op_read),
        .op_sym    (op_sym),
        .ngram_len (ngram_len)
    );

    // identical lanes, each with its own item memory copy
    for (genvar i = 0; i < `HDC_LANES; i++) begin : g_lane
        hdc_lane u_hdc_lane (
            .clk       (clk),
            .rst_n     (rst_n),
            .wr_en     (wr_en),
            .wr_addr   (wr_addr),
            .wr_data   (wr_data),
            .op_start  (op_start[i]),
            .op_accum  (op_accum[i]),
            .op_read   (op_read[i]),
            .op_sym    (op_sym),
            .ngram_len (ngram_len),
            .res_take  (res_take[i]),
            .res_valid (res_valid[i]),
            .res_busy  (res_busy[i]),
            .res_hv    (res_hv[i])
        );
    end

    hdc_collect u_hdc_collect (
        .clk       (clk),
        .rst_n     (rst_n),
        .res_valid (res_valid),
        .res_hv    (res_hv),
        .res_take  (res_take),
        .out_req   (out_req),
        .out_lane  (out_lane),
        .out_hv    (out_hv),
        .out_ack   (out_ack)
    );

endmodule

`default_nettype wire

// ==== tb_hdc_tasks.svh ====
// read the vector file, count lines up to the end marker
task automatic load_vectors();
    bit found;
    int op;
    found   = 1'b0;
    n_lines = 0;
    $readmemh("hdc_vectors.txt", vec_mem);
    for (int i = 0; i < VEC_LINES; i++) begin
        if (!found) begin
            op = int'(vec_mem[5 * i]);
            if (op == OP_END_FILE) begin
                found   = 1'b1;
                n_lines = i;
            end else if (op == OP_EXPECT) begin
                // hold applies to the result this line expects
                hold_q.push_back(int'(vec_mem[5 * i + 4]));
            end
        end
    end
    if (!found) begin
        $display("vector file has no end marker within %0d lines", VEC_LINES);
        n_errors++;
    end
endtask

task automatic check_hv(input string name, input hdc_pkg::hv_t exp, input hdc_pkg::hv_t got);
    n_checks++;
    if (got !== exp) begin
        $display("[ERROR] %s expected %h got %h", name, exp, got);
        n_errors++;
        test_errors++;
    end
endtask

task automatic check_lane(input string name, input hdc_pkg::lane_t exp,
                          input hdc_pkg::lane_t got);
    n_checks++;
    if (got !== exp) begin
        $display("[ERROR] %s expected %h got %h", name, exp, got);
        n_errors++;
        test_errors++;
    end
endtask

// four-phase command, min_seen > 0 checks this test's drain before the ack
task automatic send_cmd(input hdc_pkg::hdc_op_e op, input hdc_pkg::lane_t lane,
                        input hdc_pkg::sym_t sym, input hdc_pkg::hv_t hv, input int min_seen);
    @(posedge clk);
    #1;
    cmd_op   = op;
    cmd_lane = lane;
    cmd_sym  = sym;
    cmd_hv   = hv;
    cmd_req  = 1'b1;
    // a full result register holds the ack back
    do @(negedge clk); while (!cmd_ack);
    if (min_seen > 0) begin
        n_checks++;
        if (rx_count < min_seen) begin
            $display("read to lane %0d was acknowledged after %0d results, expected %0d",
                     lane, rx_count, min_seen);
            n_errors++;
            test_errors++;
        end
    end
    @(posedge clk);
    #1;
    cmd_req = 1'b0;
    do @(negedge clk); while (cmd_ack);
endtask

// output port responder, runs forked for the whole test
task automatic answer_results();
    int hold;
    forever begin
        do @(negedge clk); while (!out_req);
        rx_lane.push_back(out_lane);
        rx_hv.push_back(out_hv);
        rx_count++;
        hold = 0;
        if (hold_q.size() > 0) begin
            hold = hold_q.pop_front();
        end
        // slow ack, collector sits in its request state
        repeat (hold) @(negedge clk);
        @(posedge clk);
        #1;
        out_ack = 1'b1;
        do @(negedge clk); while (out_req);
        @(posedge clk);
        #1;
        out_ack = 1'b0;
    end
endtask

// next result in arrival order against one expect line
task automatic expect_result(input hdc_pkg::lane_t lane, input hdc_pkg::hv_t hv);
    hdc_pkg::lane_t got_lane;
    hdc_pkg::hv_t   got_hv;
    while (rx_lane.size() == 0) @(negedge clk);
    got_lane = rx_lane.pop_front();
    got_hv   = rx_hv.pop_front();
    check_lane("out_lane", lane, got_lane);
    check_hv("out_hv", hv, got_hv);
endtask

task automatic report_test(input int num);
    n_tests++;
    $display("test %0d %s, %0d errors", num, (test_errors == 0) ? "ok" : "failed", test_errors);
    test_errors = 0;
    // result count restarts with each test
    rx_count    = 0;
endtask

task automatic run_line(input int idx);
    int             op;
    int             arg;
    hdc_pkg::lane_t lane;
    hdc_pkg::sym_t  sym;
    hdc_pkg::hv_t   hv;
    op   = int'(vec_mem[5 * idx]);
    lane = hdc_pkg::lane_t'(vec_mem[5 * idx + 1]);
    sym  = hdc_pkg::sym_t'(vec_mem[5 * idx + 2]);
    hv   = vec_mem[5 * idx + 3];
    arg  = int'(vec_mem[5 * idx + 4]);
    case (op)
        0, 1, 2, 3, 4: send_cmd(hdc_pkg::hdc_op_e'(op[2:0]), lane, sym, hv, arg);
        OP_EXPECT:     expect_result(lane, hv);
        OP_END_TEST:   report_test(arg);
        default: begin
            $display("vector line %0d has unknown op %0d", idx, op);
            n_errors++;
        end
    endcase
endtask

// ==== tb_hdc_ngram.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "hdc_macros.svh"

module tb_hdc_ngram;

    // five words per vector line: op lane sym hv arg
    localparam int VEC_LINES = 128;
    localparam int VEC_WORDS = 5 * VEC_LINES;

    // ops above the DUT opcodes are handled here only
    localparam int OP_EXPECT   = 5;
    localparam int OP_END_TEST = 6;
    localparam int OP_END_FILE = 15;

    logic                  clk;
    logic                  rst_n;

    // host command port
    logic                  cmd_req;
    hdc_pkg::hdc_op_e      cmd_op;
    hdc_pkg::lane_t        cmd_lane;
    hdc_pkg::sym_t         cmd_sym;
    hdc_pkg::hv_t          cmd_hv;
    logic                  cmd_ack;

    // result port
    logic                  out_req;
    hdc_pkg::lane_t        out_lane;
    hdc_pkg::hv_t          out_hv;
    logic                  out_ack;

    // raw vector words, one hypervector wide
    logic [`HDC_DIM-1:0]   vec_mem [VEC_WORDS];
    int                    n_lines;
    int                    limit;
    int                    cycles;

    // results in arrival order
    hdc_pkg::lane_t        rx_lane [$];
    hdc_pkg::hv_t          rx_hv [$];
    int                    rx_count;

    // ack hold per arriving result, in expect-line order
    int                    hold_q [$];

    int                    n_tests;
    int                    n_checks;
    int                    n_errors;
    int                    test_errors;

    hdc_ngram_top u_hdc_ngram_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd_req  (cmd_req),
        .cmd_op   (cmd_op),
        .cmd_lane (cmd_lane),
        .cmd_sym  (cmd_sym),
        .cmd_hv   (cmd_hv),
        .cmd_ack  (cmd_ack),
        .out_req  (out_req),
        .out_lane (out_lane),
        .out_hv   (out_hv),
        .out_ack  (out_ack)
    );

    `include "tb_hdc_tasks.svh"

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // watchdog, limit known once the vectors are loaded
    initial begin
        cycles = 0;
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("simulation timed out after %0d cycles", cycles);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        rst_n       = 1'b0;
        cmd_req     = 1'b0;
        cmd_op      = hdc_pkg::OP_CONFIG;
        cmd_lane    = '0;
        cmd_sym     = '0;
        cmd_hv      = '0;
        out_ack     = 1'b0;
        rx_count    = 0;
        n_tests     = 0;
        n_checks    = 0;
        n_errors    = 0;
        test_errors = 0;

        load_vectors();
        // 40 cycles per line covers the longest ack hold
        limit = n_lines * 40 + 100;

        // reset held for two cycles
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        fork
            answer_results();
        join_none

        for (int i = 0; i < n_lines; i++) begin
            run_line(i);
        end

        // anything left over was never asked for
        if (rx_lane.size() != 0) begin
            $display("%0d results arrived that no vector line expected", rx_lane.size());
            n_errors++;
        end

        $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdc_ngram.f ====
+incdir+.
hdc_pkg.sv
hdc_dispatch.sv
hdc_lane.sv
hdc_collect.sv
hdc_ngram_top.sv
tb_hdc_ngram.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the hdc_ngram testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module tb_hdc_ngram -f hdc_ngram.f; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_hdc_ngram)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the testbench prints its verdict on a line of its own
if printf '%s\n' "$output" | grep -qx '>>> PASS'; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1

// ==== hdc_vectors.txt ====
// op lane sym hv arg, all hex
// op 0 config 1 load 2 start 3 accum 4 read (arg min results seen) 5 expect (arg ack hold) 6 end test f end
1 0 0 0123456789abcdef 0
1 0 1 1111111111111111 0
1 0 2 00ff00ff00ff00ff 0
1 0 3 8000000000000001 0
2 0 0 0 0
4 0 0 0 0
5 0 0 0123456789abcdef 0
2 2 3 0 0
4 2 0 0 0
5 2 0 8000000000000001 0
6 0 0 0 1
// ngram length 3, positions wrap
0 0 0 3 0
2 1 1 0 0
3 1 2 0 0
3 1 3 0 0
4 1 0 0 0
5 1 0 f16e916e916e916e 0
3 1 2 0 0
3 1 1 0 0
4 1 0 0 0
5 1 0 7919191919191919 0
6 0 0 0 2
// two lanes interleaved
2 2 3 0 0
2 3 2 0 0
3 2 1 0 0
3 3 3 0 0
3 2 2 0 0
3 3 1 0 0
4 3 0 0 0
4 2 0 0 0
5 3 0 84bb44bb44bb44bb 0
5 2 0 c8b748b748b748b6 0
6 0 0 0 3
// held output, drain order 1 2 3 0 0
4 1 0 0 0
4 0 0 0 0
4 3 0 0 0
4 2 0 0 0
4 0 0 0 3
5 1 0 7919191919191919 28
5 2 0 c8b748b748b748b6 0
5 3 0 84bb44bb44bb44bb 0
5 0 0 0123456789abcdef 0
5 0 0 0123456789abcdef 0
6 0 0 0 4
// ngram length 1, then item rewrite
0 0 0 1 0
2 0 1 0 0
3 0 2 0 0
3 0 3 0 0
4 0 0 0 0
5 0 0 91ee11ee11ee11ef 0
1 0 2 ffff0000ffff0000 0
4 0 0 0 0
5 0 0 91ee11ee11ee11ef 0
2 3 1 0 0
3 3 2 0 0
4 3 0 0 0
5 3 0 eeee1111eeee1111 0
6 0 0 0 5
f 0 0 0 0
